/* flist.f */
logic/sdram_pkg.sv
logic/wb_arbiter.sv
logic/sdram_ctrl.sv
logic/sdram_subsys_top.sv
testbench/tb_clock.sv
testbench/sdram_model.sv
testbench/sdram_ctrl_asserts.sv
testbench/sdram_subsys_tb.sv

/* run_sim.sh */
#!/bin/bash
# Compile with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sdram_subsys_tb -f flist.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    ; cat sim.log \
    && grep -q "All tests passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* testbench/sdram_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_tb;

    import sdram_pkg::*;

    localparam int t_init = 20;
    localparam int t_rp   = 2;
    localparam int t_rcd  = 2;
    localparam int t_rfc  = 6;
    localparam int t_mrd  = 2;
    localparam int t_refi = 60;
    localparam int limit  = t_init + 50 + 200 * 30;
    localparam int n_conc = 30;

    logic              clk;
    logic              reset;
    logic              m0_cyc, m0_stb, m0_we, m0_ack;
    logic              m1_cyc, m1_stb, m1_we, m1_ack;
    logic [addr_w-1:0] m0_adr, m1_adr;
    logic [data_w-1:0] m0_dat_w, m0_dat_r, m1_dat_w, m1_dat_r;
    logic              init_done;
    logic              cke, cs_n, ras_n, cas_n, we_n, dq_oe;
    logic [ba_w-1:0]   ba;
    logic [row_w-1:0]  a;
    logic [dqm_w-1:0]  dqm;
    logic [data_w-1:0] dq_out, dq_in;
    sdram_cmd_t        pin_cmd;

    logic [31:0]       lfsr_state = 32'd66387;
    logic [data_w-1:0] ref_mem [logic [addr_w-1:0]];
    sdram_cmd_t        init_cmds [$];
    int                ack_order [$];
    logic [row_w-1:0]  lmr_addr;
    logic              init_seen = 1'b0;
    logic              conc_phase = 1'b0;
    int                data_errors = 0;
    int                proto_errors = 0;
    int                refreshes = 0;
    int                run_cycles = 0;
    int                cycles = 0;

    assign pin_cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});

    tb_clock u_clock (.clk(clk), .reset(reset));

    sdram_subsys_top #(
        .t_init(t_init), .t_rp(t_rp), .t_rcd(t_rcd),
        .t_rfc(t_rfc), .t_mrd(t_mrd), .t_refi(t_refi)
    ) dut (
        .clk(clk), .reset(reset),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w), .m0_dat_r(m0_dat_r), .m0_ack(m0_ack),
        .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we), .m1_adr(m1_adr),
        .m1_dat_w(m1_dat_w), .m1_dat_r(m1_dat_r), .m1_ack(m1_ack),
        .init_done(init_done),
        .sdram_cke(cke), .sdram_cs_n(cs_n), .sdram_ras_n(ras_n),
        .sdram_cas_n(cas_n), .sdram_we_n(we_n), .sdram_ba(ba), .sdram_a(a),
        .sdram_dqm(dqm), .sdram_dq_out(dq_out), .sdram_dq_oe(dq_oe),
        .sdram_dq_in(dq_in)
    );

    sdram_model mem_model (
        .clk(clk), .cke(cke), .cs_n(cs_n), .ras_n(ras_n), .cas_n(cas_n),
        .we_n(we_n), .ba(ba), .a(a), .dqm(dqm), .dq_out(dq_out),
        .dq_oe(dq_oe), .dq_in(dq_in)
    );

    // Galois LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return r;
    endfunction

    // Small pool so that reads often hit written words
    function automatic logic [addr_w-1:0] rand_addr();
        logic [ba_w-1:0]  b;
        logic [row_w-1:0] r;
        logic [col_w-1:0] c;
        b = ba_w'(rand_bits(2));
        r = row_w'(rand_bits(2)) << 7;
        c = col_w'(rand_bits(3)) << 2;
        return {b, r, c};
    endfunction

    // Power-up content of a word in the SDRAM
    function automatic logic [data_w-1:0] expected_fill(input logic [addr_w-1:0] addr);
        return addr[15:0] ^ {addr[7:0], addr[23:16]} ^ 16'h5a3c;
    endfunction

    task automatic access(input int m, input logic we, input logic [addr_w-1:0] adr,
                          input logic [data_w-1:0] dat, input string name);
        logic [data_w-1:0] rd;
        logic [data_w-1:0] exp;
        logic              got;
        got = 1'b0;
        rd  = '0;
        if (m == 0) begin
            {m0_cyc, m0_stb, m0_we, m0_adr, m0_dat_w} = {2'b11, we, adr, dat};
        end else begin
            {m1_cyc, m1_stb, m1_we, m1_adr, m1_dat_w} = {2'b11, we, adr, dat};
        end
        while (!got) begin
            @(negedge clk);
            if ((m == 0) ? m0_ack : m1_ack) begin
                got = 1'b1;
                rd  = (m == 0) ? m0_dat_r : m1_dat_r;
            end
        end
        if (we) begin
            ref_mem[adr] = dat;
        end else begin
            exp = ref_mem.exists(adr) ? ref_mem[adr] : expected_fill(adr);
            if (rd !== exp) begin
                data_errors++;
                $display("Fail %s: master %0d adr %h expected %h actual %h",
                         name, m, adr, exp, rd);
            end
        end
        @(posedge clk);
        #1;
        if (m == 0) begin
            {m0_cyc, m0_stb} = 2'b00;
        end else begin
            {m1_cyc, m1_stb} = 2'b00;
        end
    endtask

    task automatic stream(input int m, input logic we_a [n_conc],
                          input logic [addr_w-1:0] adr_a [n_conc],
                          input logic [data_w-1:0] dat_a [n_conc]);
        for (int i = 0; i < n_conc; i++) begin
            access(m, we_a[i], adr_a[i], dat_a[i], "concurrent");
        end
    endtask

    // ------------------------------------------------------------------
    // Pin monitor for init order, refresh count and ack order
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (!init_done) begin
                if (pin_cmd != cmd_nop && pin_cmd != cmd_inhibit) begin
                    init_cmds.push_back(pin_cmd);
                end
                if (pin_cmd == cmd_lmr) lmr_addr = a;
                if (pin_cmd == cmd_precharge && !a[10]) begin
                    proto_errors++;
                    $display("Init precharge was not a precharge all");
                end
                if (m0_ack || m1_ack) begin
                    proto_errors++;
                    $display("Ack seen before init_done");
                end
            end else begin
                if (!init_seen) begin
                    init_seen = 1'b1;
                    if (init_cmds.size() == 0 || init_cmds[$] != cmd_lmr) begin
                        proto_errors++;
                        $display("init_done rose before load mode register");
                    end
                end
                run_cycles++;
                if (pin_cmd == cmd_refresh) refreshes++;
            end
            if (conc_phase && m0_ack) ack_order.push_back(0);
            if (conc_phase && m1_ack) ack_order.push_back(1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic              we_a [2][n_conc];
        logic [addr_w-1:0] adr_a [2][n_conc];
        logic [data_w-1:0] dat_a [2][n_conc];
        logic [addr_w-1:0] base;
        int                min_ref;

        {m0_cyc, m0_stb, m0_we, m0_adr, m0_dat_w} = '0;
        {m1_cyc, m1_stb, m1_we, m1_adr, m1_dat_w} = '0;
        @(negedge reset);
        @(posedge clk);
        #1;

        // Init sequence with a request waiting from the start
        access(0, 1'b1, rand_addr(), 16'(rand_bits(16)), "init_hold");
        if (init_cmds.size() != 4 || init_cmds[0] != cmd_precharge ||
            init_cmds[1] != cmd_refresh || init_cmds[2] != cmd_refresh ||
            init_cmds[3] != cmd_lmr) begin
            proto_errors++;
            $display("Init command order wrong, %0d commands seen", init_cmds.size());
        end
        if (lmr_addr !== mode_reg_value) begin
            data_errors++;
            $display("Fail init_lmr: expected %h actual %h", mode_reg_value, lmr_addr);
        end

        // Each master alone
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 50; i++) begin
                access(m, rand_bits(1) == 1, rand_addr(), 16'(rand_bits(16)), "single");
            end
        end

        // Both masters together
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < n_conc; i++) begin
                we_a[m][i]  = rand_bits(1) == 1;
                adr_a[m][i] = rand_addr();
                dat_a[m][i] = 16'(rand_bits(16));
            end
        end
        conc_phase = 1'b1;
        fork
            stream(0, we_a[0], adr_a[0], dat_a[0]);
            stream(1, we_a[1], adr_a[1], dat_a[1]);
        join
        conc_phase = 1'b0;
        for (int i = 1; i < ack_order.size(); i++) begin
            if (ack_order[i] == ack_order[i-1]) begin
                proto_errors++;
                $display("Fail arbitration: expected %0d actual %0d",
                         1 - ack_order[i-1], ack_order[i]);
            end
        end

        // Bank and row separation
        base = rand_addr();
        access(0, 1'b1, base, 16'h1111, "separation");
        access(0, 1'b1, base ^ (addr_w'(1) << 22), 16'h2222, "separation");
        access(1, 1'b1, base ^ (addr_w'(1) << 9), 16'h3333, "separation");
        access(1, 1'b0, base, 16'h0, "separation");
        access(0, 1'b0, base ^ (addr_w'(1) << 22), 16'h0, "separation");
        access(1, 1'b0, base ^ (addr_w'(1) << 9), 16'h0, "separation");

        // Idle long enough for a few more refreshes
        repeat (150) @(posedge clk);
        min_ref = run_cycles / (t_refi + 30) - 1;
        if (refreshes < min_ref) begin
            data_errors++;
            $display("Fail refresh: expected at least %0d actual %0d", min_ref, refreshes);
        end

        $display("Checks done: %0d data errors, %0d protocol errors",
                 data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sdram_ctrl_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_asserts #(
    parameter int t_rp  = 3,
    parameter int t_rcd = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  sdram_pkg::sdram_cmd_t        cmd,
    input  logic [sdram_pkg::row_w-1:0]  a,
    input  logic                         init_done
);

    import sdram_pkg::*;

    logic is_rw;

    assign is_rw = (cmd == cmd_read) || (cmd == cmd_write);

    // Only NOP while a precharge completes
    a_pre_gap: assert property (@(posedge clk) disable iff (reset)
        cmd == cmd_precharge |=> (cmd == cmd_nop) [*t_rp-1])
        else $error("command issued within t_rp of a precharge");

    a_auto_pre_gap: assert property (@(posedge clk) disable iff (reset)
        is_rw && a[10] |=> (cmd == cmd_nop) [*t_rp])
        else $error("command issued within t_rp of an auto-precharge");

    a_rcd: assert property (@(posedge clk) disable iff (reset)
        cmd == cmd_active |=> (cmd == cmd_nop) [*t_rcd-1])
        else $error("read or write closer than t_rcd to activate");

    a_init_first: assert property (@(posedge clk) disable iff (reset)
        is_rw |-> init_done)
        else $error("read or write before init_done");

endmodule

bind sdram_ctrl sdram_ctrl_asserts #(.t_rp(t_rp), .t_rcd(t_rcd)) u_asserts (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .a         (a),
    .init_done (init_done)
);

`default_nettype wire

/* testbench/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  logic                          clk,
    input  logic                          cke,
    input  logic                          cs_n,
    input  logic                          ras_n,
    input  logic                          cas_n,
    input  logic                          we_n,
    input  logic [sdram_pkg::ba_w-1:0]    ba,
    input  logic [sdram_pkg::row_w-1:0]   a,
    input  logic [sdram_pkg::dqm_w-1:0]   dqm,
    input  logic [sdram_pkg::data_w-1:0]  dq_out,
    input  logic                          dq_oe,
    output logic [sdram_pkg::data_w-1:0]  dq_in
);

    import sdram_pkg::*;

    sdram_cmd_t        cmd;
    logic [row_w-1:0]  open_row [4];
    logic [data_w-1:0] mem [logic [addr_w-1:0]];
    logic [data_w-1:0] rd_pipe [mode_cas_latency];

    assign cmd   = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
    assign dq_in = rd_pipe[mode_cas_latency-1];

    // Content of a word never written
    function automatic logic [data_w-1:0] fill_value(input logic [addr_w-1:0] addr);
        return addr[15:0] ^ {addr[7:0], addr[23:16]} ^ 16'h5a3c;
    endfunction

    function automatic logic [data_w-1:0] read_word(input logic [addr_w-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return fill_value(addr);
    endfunction

    initial begin
        for (int i = 0; i < mode_cas_latency; i++) begin
            rd_pipe[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (cke) begin
            case (cmd)
                cmd_active: open_row[ba] <= a;
                cmd_write: begin
                    if (dq_oe && dqm == '0) begin
                        mem[{ba, open_row[ba], a[col_w-1:0]}] = dq_out;
                    end
                end
                default: ;
            endcase
        end
        // Read data leaves the pipe CAS latency cycles after the command
        if (cke && cmd == cmd_read) begin
            rd_pipe[0] <= read_word({ba, open_row[ba], a[col_w-1:0]});
        end else begin
            rd_pipe[0] <= '0;
        end
        for (int i = 1; i < mode_cas_latency; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 10 ns period, reset held over the first two rising edges
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/sdram_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_subsys_top #(
    parameter int t_init = 10000,
    parameter int t_rp   = 3,
    parameter int t_rcd  = 3,
    parameter int t_rfc  = 9,
    parameter int t_mrd  = 2,
    parameter int t_refi = 780
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          m0_cyc,
    input  logic                          m0_stb,
    input  logic                          m0_we,
    input  logic [sdram_pkg::addr_w-1:0]  m0_adr,
    input  logic [sdram_pkg::data_w-1:0]  m0_dat_w,
    output logic [sdram_pkg::data_w-1:0]  m0_dat_r,
    output logic                          m0_ack,

    input  logic                          m1_cyc,
    input  logic                          m1_stb,
    input  logic                          m1_we,
    input  logic [sdram_pkg::addr_w-1:0]  m1_adr,
    input  logic [sdram_pkg::data_w-1:0]  m1_dat_w,
    output logic [sdram_pkg::data_w-1:0]  m1_dat_r,
    output logic                          m1_ack,

    output logic                          init_done,

    output logic                          sdram_cke,
    output logic                          sdram_cs_n,
    output logic                          sdram_ras_n,
    output logic                          sdram_cas_n,
    output logic                          sdram_we_n,
    output logic [sdram_pkg::ba_w-1:0]    sdram_ba,
    output logic [sdram_pkg::row_w-1:0]   sdram_a,
    output logic [sdram_pkg::dqm_w-1:0]   sdram_dqm,
    output logic [sdram_pkg::data_w-1:0]  sdram_dq_out,
    output logic                          sdram_dq_oe,
    input  logic [sdram_pkg::data_w-1:0]  sdram_dq_in
);

    import sdram_pkg::*;

    // ------------------------------------------------------------------
    // Link between arbiter and controller
    // ------------------------------------------------------------------
    logic              s_cyc;
    logic              s_stb;
    logic              s_we;
    logic [addr_w-1:0] s_adr;
    logic [data_w-1:0] s_dat_w;
    logic [data_w-1:0] s_dat_r;
    logic              s_ack;
    sdram_cmd_t        ctrl_cmd;

    // Command pins straight from the encoded command
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = ctrl_cmd;

    wb_arbiter u_arbiter (
        .clk      (clk),
        .reset    (reset),
        .m0_cyc   (m0_cyc),
        .m0_stb   (m0_stb),
        .m0_we    (m0_we),
        .m0_adr   (m0_adr),
        .m0_dat_w (m0_dat_w),
        .m0_dat_r (m0_dat_r),
        .m0_ack   (m0_ack),
        .m1_cyc   (m1_cyc),
        .m1_stb   (m1_stb),
        .m1_we    (m1_we),
        .m1_adr   (m1_adr),
        .m1_dat_w (m1_dat_w),
        .m1_dat_r (m1_dat_r),
        .m1_ack   (m1_ack),
        .s_cyc    (s_cyc),
        .s_stb    (s_stb),
        .s_we     (s_we),
        .s_adr    (s_adr),
        .s_dat_w  (s_dat_w),
        .s_dat_r  (s_dat_r),
        .s_ack    (s_ack)
    );

    sdram_ctrl #(
        .t_init (t_init),
        .t_rp   (t_rp),
        .t_rcd  (t_rcd),
        .t_rfc  (t_rfc),
        .t_mrd  (t_mrd),
        .t_refi (t_refi)
    ) u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .s_cyc     (s_cyc),
        .s_stb     (s_stb),
        .s_we      (s_we),
        .s_adr     (s_adr),
        .s_dat_w   (s_dat_w),
        .s_dat_r   (s_dat_r),
        .s_ack     (s_ack),
        .init_done (init_done),
        .cmd       (ctrl_cmd),
        .cke       (sdram_cke),
        .ba        (sdram_ba),
        .a         (sdram_a),
        .dqm       (sdram_dqm),
        .dq_out    (sdram_dq_out),
        .dq_oe     (sdram_dq_oe),
        .dq_in     (sdram_dq_in)
    );

endmodule

`default_nettype wire

/* logic/sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl #(
    parameter int t_init = 10000,
    parameter int t_rp   = 3,
    parameter int t_rcd  = 3,
    parameter int t_rfc  = 9,
    parameter int t_mrd  = 2,
    parameter int t_refi = 780
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          s_cyc,
    input  logic                          s_stb,
    input  logic                          s_we,
    input  logic [sdram_pkg::addr_w-1:0]  s_adr,
    input  logic [sdram_pkg::data_w-1:0]  s_dat_w,
    output logic [sdram_pkg::data_w-1:0]  s_dat_r,
    output logic                          s_ack,
    output logic                          init_done,

    output sdram_pkg::sdram_cmd_t         cmd,
    output logic                          cke,
    output logic [sdram_pkg::ba_w-1:0]    ba,
    output logic [sdram_pkg::row_w-1:0]   a,
    output logic [sdram_pkg::dqm_w-1:0]   dqm,
    output logic [sdram_pkg::data_w-1:0]  dq_out,
    output logic                          dq_oe,
    input  logic [sdram_pkg::data_w-1:0]  dq_in
);

    import sdram_pkg::*;

    typedef enum logic [3:0] {
        st_init_nop, st_init_pre, st_init_ref1, st_init_ref2, st_init_lmr,
        st_idle, st_refresh, st_activate, st_write, st_read, st_rd_wait
    } state_t;

    // Extra cycles after the read data so that t_rp is covered before ack
    localparam int rd_tail = (t_rp > mode_cas_latency) ? t_rp - mode_cas_latency - 1 : 0;

    state_t               state;
    state_t               nxt_state;
    sdram_cmd_t           nxt_cmd;
    logic [timer_w-1:0]   cnt;
    logic [timer_w-1:0]   nxt_dly;
    logic                 cnt_zero;
    logic [timer_w-1:0]   ref_cnt;
    logic                 ref_due;
    logic [data_w-1:0]    rd_data;
    logic [ba_w-1:0]      bank;
    logic [row_w-1:0]     row;
    logic [col_w-1:0]     col;

    assign {bank, row, col} = s_adr;
    assign cnt_zero = (cnt == '0);

    assign cke     = 1'b1;
    assign dqm     = '0;
    assign s_dat_r = rd_data;
    // Ack in the last wait cycle of an access
    assign s_ack   = ((state == st_write) || (state == st_rd_wait)) && cnt_zero;

    // ------------------------------------------------------------------
    // Next state, command and the delay of the state being entered
    // ------------------------------------------------------------------
    always_comb begin
        nxt_state = state;
        nxt_cmd   = cmd_nop;
        nxt_dly   = '0;
        case (state)
            st_init_nop: if (cnt_zero) begin
                nxt_state = st_init_pre;
                nxt_cmd   = cmd_precharge;
                nxt_dly   = timer_w'(t_rp - 1);
            end
            st_init_pre: if (cnt_zero) begin
                nxt_state = st_init_ref1;
                nxt_cmd   = cmd_refresh;
                nxt_dly   = timer_w'(t_rfc - 1);
            end
            st_init_ref1: if (cnt_zero) begin
                nxt_state = st_init_ref2;
                nxt_cmd   = cmd_refresh;
                nxt_dly   = timer_w'(t_rfc - 1);
            end
            st_init_ref2: if (cnt_zero) begin
                nxt_state = st_init_lmr;
                nxt_cmd   = cmd_lmr;
                nxt_dly   = timer_w'(t_mrd - 1);
            end
            st_idle: begin
                // Refresh goes ahead of a waiting request
                if (ref_due) begin
                    nxt_state = st_refresh;
                    nxt_cmd   = cmd_refresh;
                    nxt_dly   = timer_w'(t_rfc - 1);
                end else if (s_cyc && s_stb) begin
                    nxt_state = st_activate;
                    nxt_cmd   = cmd_active;
                    nxt_dly   = timer_w'(t_rcd - 1);
                end
            end
            st_activate: if (cnt_zero) begin
                if (s_we) begin
                    nxt_state = st_write;
                    nxt_cmd   = cmd_write;
                    nxt_dly   = timer_w'(t_rp);
                end else begin
                    nxt_state = st_read;
                    nxt_cmd   = cmd_read;
                    nxt_dly   = timer_w'(mode_cas_latency);
                end
            end
            st_read: if (cnt_zero) begin
                nxt_state = st_rd_wait;
                nxt_dly   = timer_w'(rd_tail);
            end
            st_init_lmr, st_refresh, st_write, st_rd_wait: begin
                if (cnt_zero) nxt_state = st_idle;
            end
            default: nxt_state = st_idle;
        endcase
    end

    // ------------------------------------------------------------------
    // State, delay counter, command and init flag
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_init_nop;
            cnt       <= timer_w'(t_init);
            cmd       <= cmd_inhibit;
            dq_oe     <= 1'b0;
            init_done <= 1'b0;
        end else begin
            state <= nxt_state;
            cmd   <= nxt_cmd;
            dq_oe <= (nxt_cmd == cmd_write);
            if (nxt_state != state) begin
                cnt <= nxt_dly;
            end else if (!cnt_zero) begin
                cnt <= cnt - 1'b1;
            end
            if (state == st_init_lmr && cnt_zero) begin
                init_done <= 1'b1;
            end
        end
    end

    // Refresh interval, counts only once the device is set up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ref_cnt <= timer_w'(t_refi - 1);
            ref_due <= 1'b0;
        end else begin
            if (init_done && ref_cnt == '0) begin
                ref_due <= 1'b1;
            end else if (state == st_idle) begin
                ref_due <= 1'b0;
            end
            if (!init_done || ref_cnt == '0) begin
                ref_cnt <= timer_w'(t_refi - 1);
            end else begin
                ref_cnt <= ref_cnt - 1'b1;
            end
        end
    end

    // Address, write data and read capture
    always_ff @(posedge clk) begin
        case (nxt_cmd)
            cmd_precharge: begin
                a     <= '0;
                a[10] <= 1'b1;
            end
            cmd_lmr: begin
                ba <= '0;
                a  <= mode_reg_value;
            end
            cmd_active: begin
                ba <= bank;
                a  <= row;
            end
            cmd_read, cmd_write: begin
                // A10 high selects auto-precharge
                ba           <= bank;
                a            <= '0;
                a[10]        <= 1'b1;
                a[col_w-1:0] <= col;
            end
            default: ;
        endcase
        if (nxt_cmd == cmd_write) dq_out <= s_dat_w;
        // Data is on the bus CAS latency cycles after the read
        if (state == st_read && cnt_zero) rd_data <= dq_in;
    end

endmodule

`default_nettype wire

/* logic/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          m0_cyc,
    input  logic                          m0_stb,
    input  logic                          m0_we,
    input  logic [sdram_pkg::addr_w-1:0]  m0_adr,
    input  logic [sdram_pkg::data_w-1:0]  m0_dat_w,
    output logic [sdram_pkg::data_w-1:0]  m0_dat_r,
    output logic                          m0_ack,

    input  logic                          m1_cyc,
    input  logic                          m1_stb,
    input  logic                          m1_we,
    input  logic [sdram_pkg::addr_w-1:0]  m1_adr,
    input  logic [sdram_pkg::data_w-1:0]  m1_dat_w,
    output logic [sdram_pkg::data_w-1:0]  m1_dat_r,
    output logic                          m1_ack,

    output logic                          s_cyc,
    output logic                          s_stb,
    output logic                          s_we,
    output logic [sdram_pkg::addr_w-1:0]  s_adr,
    output logic [sdram_pkg::data_w-1:0]  s_dat_w,
    input  logic [sdram_pkg::data_w-1:0]  s_dat_r,
    input  logic                          s_ack
);

    logic req0;
    logic req1;
    logic pick;
    logic sel;
    logic locked;
    logic gnt_q;
    logic last_q;

    assign req0 = m0_cyc & m0_stb;
    assign req1 = m1_cyc & m1_stb;

    // On a tie the master not served last wins
    assign pick = (req0 & req1) ? ~last_q : req1;

    // A fresh request is routed in the same cycle, a held grant wins after that
    assign sel = locked ? gnt_q : pick;

    assign s_cyc   = sel ? m1_cyc : m0_cyc;
    assign s_stb   = sel ? req1 : req0;
    assign s_we    = sel ? m1_we : m0_we;
    assign s_adr   = sel ? m1_adr : m0_adr;
    assign s_dat_w = sel ? m1_dat_w : m0_dat_w;

    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;
    assign m0_ack   = s_ack & ~sel;
    assign m1_ack   = s_ack & sel;

    // Grant is held from the first cycle of a request until its ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            locked <= 1'b0;
            gnt_q  <= 1'b0;
            last_q <= 1'b1;
        end else if (s_ack) begin
            locked <= 1'b0;
            last_q <= sel;
        end else if (!locked && (req0 || req1)) begin
            locked <= 1'b1;
            gnt_q  <= pick;
        end
    end

endmodule

`default_nettype wire

/* logic/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

    // ------------------------------------------------------------------
    // Geometry of the 16-bit SDR SDRAM
    // ------------------------------------------------------------------
    localparam int ba_w    = 2;
    localparam int row_w   = 13;
    localparam int col_w   = 9;
    localparam int dqm_w   = 2;
    localparam int addr_w  = ba_w + row_w + col_w;
    localparam int data_w  = 16;

    // Width of the controller delay and refresh counters
    localparam int timer_w = 16;

    // Command bits are {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_inhibit   = 4'b1111,
        cmd_nop       = 4'b0111,
        cmd_active    = 4'b0011,
        cmd_read      = 4'b0101,
        cmd_write     = 4'b0100,
        cmd_precharge = 4'b0010,
        cmd_refresh   = 4'b0001,
        cmd_lmr       = 4'b0000
    } sdram_cmd_t;

    // ------------------------------------------------------------------
    // Mode register fields
    // ------------------------------------------------------------------
    localparam int         mode_cas_latency    = 2;
    localparam logic [2:0] mode_burst_len_code = 3'b000;
    // Sequential
    localparam logic       mode_burst_type     = 1'b0;
    // Single location write
    localparam logic       mode_wr_burst_mode  = 1'b1;

    // A[12:10] reserved, A[8:7] standard operation
    localparam logic [12:0] mode_reg_value = {3'b000, mode_wr_burst_mode, 2'b00,
                                              3'(mode_cas_latency), mode_burst_type,
                                              mode_burst_len_code};

endpackage

`default_nettype wire
